//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := uart_bridge_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/uart_pkg.sv
rtl/bridge_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/byte_fifo.sv
rtl/command_engine.sv
rtl/target_bus.sv
rtl/uart_bridge_top.sv
verification/uart_bridge_tb.sv

//--- rtl/bridge_pkg.sv
// Bridge command and bus types
`default_nettype none

package bridge_pkg;

    localparam int CMD_LENGTH = 13;                             // Header, select, data
    localparam logic [8*(CMD_LENGTH-2)-1:0] CMD_HEADER = "pb_i_write,";

    localparam int REPLY_LENGTH = 6;                            // Text plus CR LF
    localparam logic [8*REPLY_LENGTH-1:0] REPLY_PASS = {"Pass", 8'h0d, 8'h0a};
    localparam logic [8*REPLY_LENGTH-1:0] REPLY_FAIL = {"Fail", 8'h0d, 8'h0a};

    typedef logic [2:0] bus_addr_t;         // Target address lines
    typedef logic [7:0] bus_data_t;         // Target data lines

    // Select byte, checked raw and then split into bus fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [3:0] reserved;           // Must be zero
            logic       test_addr;          // Test-address line
            bus_addr_t  addr;               // Bus address
        } fields;
    } bus_sel_u;

endpackage

`default_nettype wire

//--- rtl/byte_fifo.sv
// Byte FIFO
`timescale 1ns/1ns
`default_nettype none

module byte_fifo import uart_pkg::*; #(
    parameter int FIFO_DEPTH = 16                   // Power of two
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       wr,
    input  uart_byte_t wr_data,
    input  logic       rd,
    output uart_byte_t rd_data,                     // Head entry, fall-through
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    uart_byte_t    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;                           // Entries held
    logic          do_wr;
    logic          do_rd;

    assign do_wr   = wr && !full;                   // Full drops the byte
    assign do_rd   = rd && !empty;
    assign empty   = (count == '0);
    assign full    = (count == (AW+1)'(FIFO_DEPTH));
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
        end
    end

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Producer and consumer must respect the flags
    assert property (@(posedge clock) disable iff (!rst_n) !(wr && full))
        else $error("byte_fifo: write to full FIFO, byte lost");
    assert property (@(posedge clock) disable iff (!rst_n) !(rd && empty))
        else $error("byte_fifo: read from empty FIFO");

endmodule

`default_nettype wire

//--- rtl/command_engine.sv
// Command parser and replies
`timescale 1ns/1ns
`default_nettype none

module command_engine
    import uart_pkg::*;
    import bridge_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  uart_byte_t rx_data,                     // Receive FIFO head
    input  logic       rx_empty,
    input  logic       tx_full,
    input  logic       bus_busy,                    // Sequencer busy or in reset
    output logic       rx_rd,
    output logic       tx_wr,
    output uart_byte_t tx_data,                     // Reply byte
    output logic       write_start,                 // One-cycle bus request
    output bus_addr_t  write_addr,
    output logic       write_test_addr,
    output bus_data_t  write_data
);

    localparam int HDR_LEN = $bits(CMD_HEADER) / 8;
    localparam int IDX_W   = $clog2(CMD_LENGTH);

    typedef enum logic [1:0] {
        ST_COLLECT,                                 // Pull command bytes
        ST_CHECK,                                   // Header and select check
        ST_WAIT,                                    // Bus write running
        ST_REPLY                                    // Queue reply text
    } state_t;

    state_t                  state;
    logic [IDX_W-1:0]        idx;                   // Command or reply byte index
    uart_byte_t              cmd_buf [CMD_LENGTH];
    logic [$bits(CMD_HEADER)-1:0] hdr_word;         // First bytes as one word
    bus_sel_u                sel;
    logic                    hdr_ok;
    logic                    sel_ok;
    logic                    reply_pass;            // Pass or Fail text
    logic [8*REPLY_LENGTH-1:0] reply_word;

    // First byte lands in the top of the word
    always_comb begin
        for (int i = 0; i < HDR_LEN; i++) begin
            hdr_word[8*(HDR_LEN-1-i) +: 8] = cmd_buf[i];
        end
    end

    assign sel.raw = cmd_buf[CMD_LENGTH-2];
    assign hdr_ok  = (hdr_word == CMD_HEADER);
    assign sel_ok  = (sel.raw[7:4] == 4'h0);       // Upper nibble reserved

    // Buffer is frozen until the write is done
    assign write_addr      = sel.fields.addr;
    assign write_test_addr = sel.fields.test_addr;
    assign write_data      = cmd_buf[CMD_LENGTH-1];

    assign rx_rd      = (state == ST_COLLECT) && !rx_empty && !bus_busy;
    assign tx_wr      = (state == ST_REPLY) && !tx_full;
    assign reply_word = reply_pass ? REPLY_PASS : REPLY_FAIL;
    assign tx_data    = reply_word[8*(REPLY_LENGTH-1-idx) +: 8];    // Text order

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state       <= ST_COLLECT;
            idx         <= '0;
            write_start <= 1'b0;
            reply_pass  <= 1'b0;
        end else begin
            write_start <= 1'b0;                    // Single-cycle strobe
            case (state)
                ST_COLLECT: begin
                    if (rx_rd) begin
                        if (idx == IDX_W'(CMD_LENGTH - 1)) begin
                            idx   <= '0;
                            state <= ST_CHECK;      // Whole command in
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                ST_CHECK: begin
                    reply_pass <= hdr_ok && sel_ok;
                    if (hdr_ok && sel_ok) begin
                        write_start <= 1'b1;
                        state       <= ST_WAIT;
                    end else begin
                        state <= ST_REPLY;          // No bus cycle on Fail
                    end
                end
                ST_WAIT: begin
                    // Busy rises a cycle after the strobe
                    if (!write_start && !bus_busy) begin
                        state <= ST_REPLY;
                    end
                end
                ST_REPLY: begin
                    if (tx_wr) begin
                        if (idx == IDX_W'(REPLY_LENGTH - 1)) begin
                            idx   <= '0;
                            state <= ST_COLLECT;
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= ST_COLLECT;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rx_rd) begin
            cmd_buf[idx] <= rx_data;
        end
    end

    // Sequencer takes no request while busy
    assert property (@(posedge clock) disable iff (!rst_n) write_start |-> !bus_busy)
        else $error("command_engine: write_start while bus busy");

endmodule

`default_nettype wire

//--- rtl/target_bus.sv
// Target bus sequencer
`timescale 1ns/1ns
`default_nettype none

module target_bus import bridge_pkg::*; #(
    parameter int RESET_CYCLES = 100,               // Target reset hold
    parameter int WRITE_CYCLES = 4                  // Write strobe width
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      write_start,
    input  bus_addr_t write_addr,
    input  logic      write_test_addr,
    input  bus_data_t write_data,
    output logic      busy,                         // High in reset phase and writes
    output bus_data_t data_p,
    output bus_addr_t addr_p,
    output logic      test_addr_p,
    output logic      b0_p,                         // Board enable
    output logic      rd_p,
    output logic      wr_p,
    output logic      reset_p                       // Target reset
);

    localparam int RST_W = $clog2(RESET_CYCLES + 1);
    localparam int WR_W  = $clog2(WRITE_CYCLES + 1);

    logic [RST_W-1:0] rst_cnt;
    logic [WR_W-1:0]  wr_cnt;

    assign rd_p = 1'b0;                             // Writes only

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rst_cnt     <= '0;
            wr_cnt      <= '0;
            busy        <= 1'b1;
            reset_p     <= 1'b1;                    // Hold target in reset
            b0_p        <= 1'b0;
            wr_p        <= 1'b0;
            data_p      <= '0;
            addr_p      <= '0;
            test_addr_p <= 1'b0;
        end else if (reset_p) begin
            if (rst_cnt == RST_W'(RESET_CYCLES - 1)) begin
                reset_p <= 1'b0;
                b0_p    <= 1'b1;                    // Enable the board
                busy    <= 1'b0;
            end else begin
                rst_cnt <= rst_cnt + 1'b1;
            end
        end else if (wr_p) begin
            if (wr_cnt == WR_W'(WRITE_CYCLES - 1)) begin
                wr_p <= 1'b0;
            end else begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end else if (busy) begin
            busy <= 1'b0;                           // Recovery cycle after strobe
        end else if (write_start) begin
            busy        <= 1'b1;
            wr_p        <= 1'b1;
            wr_cnt      <= '0;
            data_p      <= write_data;
            addr_p      <= write_addr;
            test_addr_p <= write_test_addr;
        end
    end

    // Bus lines held for the whole strobe
    assert property (@(posedge clock) disable iff (!rst_n)
        $past(wr_p) && wr_p |-> $stable({data_p, addr_p, test_addr_p}))
        else $error("target_bus: bus lines changed during write strobe");

endmodule

`default_nettype wire

//--- rtl/uart_bridge_top.sv
// UART to parallel bus bridge
`timescale 1ns/1ns
`default_nettype none

module uart_bridge_top
    import uart_pkg::*;
    import bridge_pkg::*;
#(
    parameter int CLKS_PER_BIT = 234,               // 27 MHz at 115200 baud
    parameter int FIFO_DEPTH   = 16,
    parameter int RESET_CYCLES = 100,
    parameter int WRITE_CYCLES = 4
) (
    input  logic      clock,
    input  logic      rst_n,
    input  logic      rx_pin,
    output logic      tx_pin,
    output bus_data_t data_p,
    output bus_addr_t addr_p,
    output logic      test_addr_p,
    output logic      b0_p,
    output logic      rd_p,
    output logic      wr_p,
    output logic      reset_p
);

    uart_byte_t rx_byte;                            // Receiver to FIFO
    logic       rx_valid;
    uart_byte_t rx_data;                            // FIFO head to engine
    logic       rx_empty;
    logic       rx_rd;
    uart_byte_t tx_data;                            // Engine to FIFO
    logic       tx_wr;
    logic       tx_full;
    uart_byte_t tx_head;                            // FIFO head to transmitter
    logic       tx_empty;
    logic       tx_rd;
    logic       write_start;
    bus_addr_t  write_addr;
    logic       write_test_addr;
    bus_data_t  write_data;
    logic       bus_busy;

    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
        .clock    (clock),
        .rst_n    (rst_n),
        .rx_pin   (rx_pin),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
        .clock   (clock),
        .rst_n   (rst_n),
        .wr      (rx_valid),
        .wr_data (rx_byte),
        .rd      (rx_rd),
        .rd_data (rx_data),
        .empty   (rx_empty),
        .full    ()                                 // Engine drains faster than bytes arrive
    );

    command_engine command_engine_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .rx_data         (rx_data),
        .rx_empty        (rx_empty),
        .tx_full         (tx_full),
        .bus_busy        (bus_busy),
        .rx_rd           (rx_rd),
        .tx_wr           (tx_wr),
        .tx_data         (tx_data),
        .write_start     (write_start),
        .write_addr      (write_addr),
        .write_test_addr (write_test_addr),
        .write_data      (write_data)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
        .clock   (clock),
        .rst_n   (rst_n),
        .wr      (tx_wr),
        .wr_data (tx_data),
        .rd      (tx_rd),
        .rd_data (tx_head),
        .empty   (tx_empty),
        .full    (tx_full)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .fifo_data  (tx_head),
        .fifo_empty (tx_empty),
        .fifo_rd    (tx_rd),
        .tx_pin     (tx_pin)
    );

    target_bus #(
        .RESET_CYCLES (RESET_CYCLES),
        .WRITE_CYCLES (WRITE_CYCLES)
    ) target_bus_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .write_start     (write_start),
        .write_addr      (write_addr),
        .write_test_addr (write_test_addr),
        .write_data      (write_data),
        .busy            (bus_busy),
        .data_p          (data_p),
        .addr_p          (addr_p),
        .test_addr_p     (test_addr_p),
        .b0_p            (b0_p),
        .rd_p            (rd_p),
        .wr_p            (wr_p),
        .reset_p         (reset_p)
    );

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
// Serial link types
`default_nettype none

package uart_pkg;

    typedef logic [7:0] uart_byte_t;        // One data byte of a frame

    // 8N1 framing
    localparam int FRAME_BITS = 10;         // Start, eight data, stop

endpackage

`default_nettype wire

//--- rtl/uart_rx.sv
// UART receiver
`timescale 1ns/1ns
`default_nettype none

module uart_rx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 234                // Clocks per serial bit
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       rx_pin,                      // Serial input, idles high
    output uart_byte_t rx_byte,                     // Last framed byte
    output logic       rx_valid                     // Pulse mid stop bit
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(FRAME_BITS);

    logic [1:0]       rx_sync;                      // Two-flop synchroniser
    logic             line;                         // Synchronised pin level
    logic             busy;                         // Inside a frame
    logic [CNT_W-1:0] clk_cnt;                      // Clocks to next bit centre
    logic [IDX_W-1:0] bit_idx;                      // 0 start, 1..8 data, then stop
    logic             sample;                       // At a bit centre
    uart_byte_t       shift;                        // Data bits, LSB first

    assign line    = rx_sync[1];
    assign sample  = busy && (clk_cnt == '0);
    assign rx_byte = shift;                         // Held until next data bit

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_sync  <= {rx_sync[0], rx_pin};
            rx_valid <= 1'b0;                       // Default no strobe
            if (!busy) begin
                if (!line) begin                    // Start edge
                    busy    <= 1'b1;
                    clk_cnt <= CNT_W'(CLKS_PER_BIT / 2 - 1);
                    bit_idx <= '0;
                end
            end else if (!sample) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);    // One bit to next centre
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == '0 && line) begin
                    busy <= 1'b0;                   // Glitch, no real start bit
                end else if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                    busy     <= 1'b0;
                    rx_valid <= line;               // Bad stop bit drops the byte
                end
            end
        end
    end

    // Data bits only, start and stop are not stored
    always_ff @(posedge clock) begin
        if (sample && bit_idx != '0 && bit_idx != IDX_W'(FRAME_BITS - 1)) begin
            shift <= {line, shift[7:1]};            // LSB arrives first
        end
    end

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
// UART transmitter
`timescale 1ns/1ns
`default_nettype none

module uart_tx import uart_pkg::*; #(
    parameter int CLKS_PER_BIT = 234                // Clocks per serial bit
) (
    input  logic       clock,
    input  logic       rst_n,
    input  uart_byte_t fifo_data,                   // FIFO head byte
    input  logic       fifo_empty,
    output logic       fifo_rd,                     // Pop strobe
    output logic       tx_pin                       // Serial output, idles high
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int IDX_W = $clog2(FRAME_BITS);

    logic                  busy;                    // Frame on the line
    logic [CNT_W-1:0]      clk_cnt;                 // Clocks left in this bit
    logic [IDX_W-1:0]      bit_idx;                 // Bit now on the line
    logic                  bit_end;                 // Last clock of a bit
    logic [FRAME_BITS-2:0] frame;                   // Data and stop still to send

    assign fifo_rd = !busy && !fifo_empty;          // Pop loop
    assign bit_end = busy && (clk_cnt == '0);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_idx <= '0;
            tx_pin  <= 1'b1;
        end else if (fifo_rd) begin
            busy    <= 1'b1;
            clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
            bit_idx <= '0;
            tx_pin  <= 1'b0;                        // Start bit
        end else if (bit_end) begin
            clk_cnt <= CNT_W'(CLKS_PER_BIT - 1);
            if (bit_idx == IDX_W'(FRAME_BITS - 1)) begin
                busy <= 1'b0;                       // Stop bit done
            end else begin
                tx_pin  <= frame[0];
                bit_idx <= bit_idx + 1'b1;
            end
        end else if (busy) begin
            clk_cnt <= clk_cnt - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (fifo_rd) begin
            frame <= {1'b1, fifo_data};             // Stop bit above data
        end else if (bit_end) begin
            frame <= {1'b1, frame[FRAME_BITS-2:1]};
        end
    end

endmodule

`default_nettype wire

//--- verification/uart_bridge_golden.txt
// Columns: 13 command bytes (header, select, data), reply 1 Pass 0 Fail,
// expected addr_p, test_addr_p, data_p. All values hex, one test per line
70 62 5f 69 5f 77 72 69 74 65 2c 05 a5 01 05 00 a5
70 62 5f 69 5f 77 72 69 74 65 2c 0b 3c 01 03 01 3c
70 62 5f 69 5f 57 72 69 74 65 2c 02 11 00 00 00 00
70 62 5f 69 5f 77 72 69 74 65 2c 85 7e 00 00 00 00
70 62 5f 69 5f 77 72 69 74 65 2c 10 ff 00 00 00 00
70 62 5f 69 5f 77 72 69 74 65 2c 0f 00 01 07 01 00
70 62 5f 69 5f 77 72 69 74 65 2c 00 ff 01 00 00 ff
70 62 5f 69 5f 77 72 69 74 65 3b 04 44 00 00 00 00
50 62 5f 69 5f 77 72 69 74 65 2c 06 5a 00 00 00 00
70 62 5f 69 5f 77 72 69 74 65 2c 40 c3 00 00 00 00
70 62 5f 69 5f 77 72 69 74 65 2c 0c 96 01 04 01 96
70 62 5f 69 5f 77 72 69 74 65 2c 01 81 01 01 00 81

//--- verification/uart_bridge_tb.sv
// UART bridge testbench
`timescale 1ns/1ns
`default_nettype none

module uart_bridge_tb import uart_pkg::*, bridge_pkg::*; ;

    localparam int CLKS_PER_BIT   = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int WRITE_CYCLES   = 4;                  // DUT default strobe width
    localparam int N_GOLDEN       = 12;
    localparam int N_RANDOM       = 4;
    localparam int N_TESTS        = N_GOLDEN + N_RANDOM;
    localparam int REC_LEN        = CMD_LENGTH + 4;     // Command, reply, addr, test addr, data
    localparam int TIMEOUT_CYCLES = N_TESTS * (19 * FRAME_BITS * CLKS_PER_BIT + 200);

    logic       clock = 1'b0;
    logic       rst_n;
    logic       rx_pin;
    logic       tx_pin;
    bus_data_t  data_p;
    bus_addr_t  addr_p;
    logic       test_addr_p;
    logic       b0_p;
    logic       rd_p;
    logic       wr_p;
    logic       reset_p;

    uart_byte_t golden [N_GOLDEN*REC_LEN];              // Raw golden records
    uart_byte_t cmd_bytes [N_TESTS][CMD_LENGTH];
    logic       exp_pass [N_TESTS];
    bus_addr_t  exp_addr [N_TESTS];
    logic       exp_ta [N_TESTS];
    bus_data_t  exp_data [N_TESTS];
    uart_byte_t reply_q [$];                            // Bytes decoded from tx_pin
    bus_addr_t  wr_addr_q [$];                          // One entry per wr_p pulse
    logic       wr_ta_q [$];
    bus_data_t  wr_data_q [$];
    int         wr_width_q [$];
    int         errors = 0;
    int         n_pass = 0;
    int         n_fail = 0;
    int         cycle_count = 0;

    uart_bridge_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .RESET_CYCLES (RESET_CYCLES)
    ) uart_bridge_top_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .rx_pin      (rx_pin),
        .tx_pin      (tx_pin),
        .data_p      (data_p),
        .addr_p      (addr_p),
        .test_addr_p (test_addr_p),
        .b0_p        (b0_p),
        .rd_p        (rd_p),
        .wr_p        (wr_p),
        .reset_p     (reset_p)
    );

    always #20 clock = ~clock;                          // 40 ns period

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: run stopped after %0d cycles, replies did not arrive", cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input bus_addr_t got, input bus_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // Golden records first, then random select and data with a fixed header
    task automatic load_tests();
        logic [31:0] state;
        bus_sel_u    sel;
        $readmemh("verification/uart_bridge_golden.txt", golden);
        for (int t = 0; t < N_GOLDEN; t++) begin
            for (int i = 0; i < CMD_LENGTH; i++) cmd_bytes[t][i] = golden[REC_LEN*t + i];
            exp_pass[t] = golden[REC_LEN*t + CMD_LENGTH][0];
            exp_addr[t] = golden[REC_LEN*t + CMD_LENGTH + 1][2:0];
            exp_ta[t]   = golden[REC_LEN*t + CMD_LENGTH + 2][0];
            exp_data[t] = golden[REC_LEN*t + CMD_LENGTH + 3];
        end
        state = 32'h3e76_c465;
        for (int t = N_GOLDEN; t < N_TESTS; t++) begin
            state = xorshift(state);
            sel.raw = state[7:0];
            if (state[31]) sel.raw[7:4] = 4'h0;         // About half are legal
            for (int i = 0; i < CMD_LENGTH - 2; i++) begin
                cmd_bytes[t][i] = CMD_HEADER[8*(CMD_LENGTH-3-i) +: 8];
            end
            cmd_bytes[t][CMD_LENGTH-2] = sel.raw;
            cmd_bytes[t][CMD_LENGTH-1] = state[23:16];
            exp_pass[t] = (sel.raw[7:4] == 4'h0);       // Reserved nibble must be zero
            exp_addr[t] = sel.fields.addr;
            exp_ta[t]   = sel.fields.test_addr;
            exp_data[t] = state[23:16];
        end
    endtask

    // 8N1 frame, LSB first, one bit per CLKS_PER_BIT clocks
    task automatic send_byte(input uart_byte_t b);
        logic bit_val;
        for (int k = 0; k < FRAME_BITS; k++) begin
            if (k == 0) bit_val = 1'b0;
            else if (k == FRAME_BITS - 1) bit_val = 1'b1;
            else bit_val = b[k-1];
            @(posedge clock);
            rx_pin <= bit_val;
            repeat (CLKS_PER_BIT - 1) @(posedge clock);
        end
    endtask

    task automatic send_all();
        for (int t = 0; t < N_TESTS; t++) begin
            for (int i = 0; i < CMD_LENGTH; i++) send_byte(cmd_bytes[t][i]);   // No gaps
        end
    endtask

    task automatic check_reset_phase();
        int cycles;
        int err_before;
        err_before = errors;
        @(negedge clock);
        while (!rst_n) @(negedge clock);
        cycles = 0;
        while (reset_p && cycles <= RESET_CYCLES + 5) begin
            check_bit("b0_p", b0_p, 1'b0);
            cycles++;
            @(negedge clock);
        end
        check_count("reset_p high cycles", cycles, RESET_CYCLES);
        check_bit("b0_p", b0_p, 1'b1);
        check_bit("wr_p", wr_p, 1'b0);
        check_bit("rd_p", rd_p, 1'b0);
        if (errors == err_before) n_pass++;
        else n_fail++;
        $display("reset phase: %s", (errors == err_before) ? "ok" : "mismatch");
    endtask

    task automatic check_replies();
        int         err_before;
        uart_byte_t exp;
        for (int t = 0; t < N_TESTS; t++) begin
            err_before = errors;
            while (reply_q.size() < REPLY_LENGTH) @(negedge clock);
            for (int i = 0; i < REPLY_LENGTH; i++) begin
                exp = exp_pass[t] ? REPLY_PASS[8*(REPLY_LENGTH-1-i) +: 8]
                                  : REPLY_FAIL[8*(REPLY_LENGTH-1-i) +: 8];
                check_byte("tx_pin reply byte", reply_q.pop_front(), exp);
            end
            if (exp_pass[t] && wr_addr_q.size() == 0) begin
                report_error("valid command gave no bus write");
            end else if (exp_pass[t]) begin
                check_addr("addr_p", wr_addr_q.pop_front(), exp_addr[t]);
                check_bit("test_addr_p", wr_ta_q.pop_front(), exp_ta[t]);
                check_data("data_p", wr_data_q.pop_front(), exp_data[t]);
                check_count("wr_p width", wr_width_q.pop_front(), WRITE_CYCLES);
            end else if (wr_addr_q.size() != 0) begin
                report_error("rejected command still wrote to the bus");
                wr_addr_q.delete();
                wr_ta_q.delete();
                wr_data_q.delete();
                wr_width_q.delete();
            end
            if (errors == err_before) n_pass++;
            else n_fail++;
            $display("test %0d (%s expected): %s", t, exp_pass[t] ? "Pass" : "Fail",
                     (errors == err_before) ? "ok" : "mismatch");
        end
    endtask

    // Samples tx_pin on falling edges, mid bit
    initial begin : reply_decoder
        uart_byte_t b;
        forever begin
            @(negedge clock);
            if (rst_n && !tx_pin) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clock);
                if (tx_pin) begin
                    report_error("start bit on tx_pin shorter than half a bit");
                end else begin
                    for (int i = 0; i < FRAME_BITS - 2; i++) begin
                        repeat (CLKS_PER_BIT) @(negedge clock);
                        b[i] = tx_pin;
                    end
                    repeat (CLKS_PER_BIT) @(negedge clock);
                    if (!tx_pin) report_error("stop bit missing on tx_pin");
                    else reply_q.push_back(b);
                end
            end
        end
    end

    // Captures bus lines at each wr_p rise, width at its fall
    initial begin : bus_monitor
        logic      wr_prev;
        bus_addr_t addr_cap;
        logic      ta_cap;
        bus_data_t data_cap;
        int        width;
        wr_prev = 1'b0;
        width   = 0;
        forever begin
            @(negedge clock);
            if (rd_p === 1'b1) report_error("rd_p went high, reads are not supported");
            if (wr_p === 1'b1 && !wr_prev) begin
                addr_cap = addr_p;
                ta_cap   = test_addr_p;
                data_cap = data_p;
                width    = 0;
            end
            if (wr_p === 1'b1) width++;
            if (wr_p !== 1'b1 && wr_prev) begin
                wr_addr_q.push_back(addr_cap);
                wr_ta_q.push_back(ta_cap);
                wr_data_q.push_back(data_cap);
                wr_width_q.push_back(width);
            end
            wr_prev = (wr_p === 1'b1);
        end
    end

    initial begin
        rst_n  <= 1'b0;
        rx_pin <= 1'b1;                                 // Line idles high
        load_tests();
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
        fork
            send_all();
            begin
                check_reset_phase();
                check_replies();
            end
        join
        repeat (2 * FRAME_BITS * CLKS_PER_BIT) @(posedge clock);
        if (reply_q.size() != 0) report_error("extra reply bytes after the last test");
        if (wr_addr_q.size() != 0) report_error("extra bus writes after the last test");
        $display("summary: %0d passed, %0d failed, %0d errors", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
